// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = ql_agent_tb
FILELIST  = verilog.f
RUNFLAGS  = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP) $(RUNFLAGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== rtl/action_select.sv ====
`timescale 1ns/100ps

module action_select (
    input  logic            clk,
    input  logic            reset,
    input  logic            sel_en,
    input  logic [15:0]     epsilon,
    input  ql_pkg::action_t next_action,
    input  ql_pkg::q_row_t  q_row,
    output ql_pkg::action_t action
);

    localparam logic [15:0] lfsr_seed = 16'hACE1;

    logic [15:0]     lfsr;
    logic [15:0]     draw;
    logic            feedback;
    ql_pkg::action_t greedy;
    ql_pkg::q_t      best_q;

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // lfsr never holds zero, so the draw spans 0 to FFFE
    assign draw = lfsr - 16'd1;

    // argmax over the row
    always_comb begin
        greedy = ql_pkg::ACT_UP;
        best_q = q_row[0];
        for (int i = 1; i < 4; i++) begin
            // strict compare, ties keep the lower index
            if (q_row[i] > best_q) begin
                greedy = ql_pkg::action_t'(i);
                best_q = q_row[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr   <= lfsr_seed;
            action <= ql_pkg::ACT_UP;
        end else if (sel_en) begin
            lfsr <= {lfsr[14:0], feedback};
            if (draw < epsilon) begin
                // explore
                action <= next_action;
            end else begin
                action <= greedy;
            end
        end
    end

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/100ps
`include "ql_cfg.svh"

module control_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                enb,
    input  ql_pkg::env_result_t result,
    output logic                sel_en,
    output logic                move_en,
    output logic                wr_en,
    output logic                start_episode,
    output logic                step_done,
    output logic                fail,
    output logic                finish,
    output logic [8:0]          episode,
    output logic                done
);

    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        MOVE,
        EVAL,
        WRITE
    } phase_t;

    phase_t phase;
    phase_t phase_next;
    logic   terminal;
    logic   last_episode;

    assign terminal = result.hole | result.goal;

    // this step closes the final episode
    assign last_episode = terminal && (episode == (`QL_MAX_EPISODES - 9'd1));

    always_comb begin
        phase_next = phase;
        case (phase)
            IDLE: begin
                if (enb && (episode != `QL_MAX_EPISODES)) begin
                    phase_next = SELECT;
                end
            end
            SELECT: begin
                if (enb) begin
                    phase_next = MOVE;
                end else begin
                    phase_next = IDLE;
                end
            end
            MOVE:  phase_next = EVAL;
            EVAL:  phase_next = WRITE;
            WRITE: begin
                if (last_episode) begin
                    phase_next = IDLE;
                end else begin
                    phase_next = SELECT;
                end
            end
            default: phase_next = IDLE;
        endcase
    end

    assign sel_en        = (phase == SELECT) && enb;
    assign move_en       = (phase == WRITE);
    assign wr_en         = (phase == WRITE);
    assign start_episode = (phase == WRITE) && terminal;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= IDLE;
            episode   <= '0;
            step_done <= 1'b0;
            fail      <= 1'b0;
            finish    <= 1'b0;
            done      <= 1'b0;
        end else begin
            phase     <= phase_next;
            // pulses line up with the committed state
            step_done <= (phase == WRITE);
            fail      <= (phase == WRITE) && result.hole;
            finish    <= (phase == WRITE) && result.goal;
            done      <= (episode == `QL_MAX_EPISODES);
            if (start_episode) begin
                episode <= episode + 9'd1;
            end
        end
    end

endmodule

// ==== rtl/grid_env.sv ====
`timescale 1ns/100ps
`include "ql_cfg.svh"

module grid_env (
    input  logic                clk,
    input  logic                reset,
    input  logic                start_episode,
    input  logic                move_en,
    input  ql_pkg::action_t     action,
    output ql_pkg::state_t      current_st,
    output ql_pkg::env_result_t result
);

    localparam ql_pkg::state_t grid_n = ql_pkg::state_t'(`QL_GRID_N);
    localparam logic [`QL_STATES-1:0] hole_mask = `QL_HOLE_MASK;

    ql_pkg::state_t      cell_row;
    ql_pkg::state_t      cell_col;
    ql_pkg::state_t      neighbor;
    ql_pkg::env_result_t move_res;

    assign cell_row = current_st / grid_n;
    assign cell_col = current_st % grid_n;

    // a move off the edge leaves the agent in place
    always_comb begin
        neighbor = current_st;
        case (action)
            ql_pkg::ACT_UP: begin
                if (cell_row != '0) begin
                    neighbor = current_st - grid_n;
                end
            end
            ql_pkg::ACT_DOWN: begin
                if (cell_row != grid_n - 5'd1) begin
                    neighbor = current_st + grid_n;
                end
            end
            ql_pkg::ACT_LEFT: begin
                if (cell_col != '0) begin
                    neighbor = current_st - 5'd1;
                end
            end
            ql_pkg::ACT_RIGHT: begin
                if (cell_col != grid_n - 5'd1) begin
                    neighbor = current_st + 5'd1;
                end
            end
            default: neighbor = current_st;
        endcase
    end

    // classify the target cell
    always_comb begin
        move_res.next_state = neighbor;
        move_res.hole       = hole_mask[neighbor];
        move_res.goal       = (neighbor == `QL_GOAL);
        if (move_res.goal) begin
            move_res.reward = `QL_R_GOAL;
        end else if (move_res.hole) begin
            move_res.reward = `QL_R_HOLE;
        end else begin
            move_res.reward = `QL_R_STEP;
        end
    end

    // pipeline stage, valid from EVAL on
    always_ff @(posedge clk) begin
        result <= move_res;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_st <= `QL_START;
        end else if (start_episode) begin
            current_st <= `QL_START;
        end else if (move_en) begin
            current_st <= result.next_state;
        end
    end

endmodule

// ==== rtl/q_table.sv ====
`timescale 1ns/100ps
`include "ql_cfg.svh"

module q_table (
    input  logic            clk,
    input  logic            reset,
    input  ql_pkg::state_t  rd_state_a,
    output ql_pkg::q_row_t  rd_row_a,
    input  ql_pkg::state_t  rd_state_b,
    output ql_pkg::q_row_t  rd_row_b,
    input  logic            wr_en,
    input  ql_pkg::state_t  wr_state,
    input  ql_pkg::action_t wr_action,
    input  ql_pkg::q_t      wr_value
);

    ql_pkg::q_row_t q_mem [`QL_STATES];

    // current row and next-state row
    assign rd_row_a = q_mem[rd_state_a];
    assign rd_row_b = q_mem[rd_state_b];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `QL_STATES; s++) begin
                q_mem[s] <= '0;
            end
        end else if (wr_en) begin
            // single entry, other actions of the row untouched
            q_mem[wr_state][wr_action] <= wr_value;
        end
    end

endmodule

// ==== rtl/q_update.sv ====
`timescale 1ns/100ps
`include "ql_cfg.svh"

module q_update (
    input  ql_pkg::q_t     q_old,
    input  ql_pkg::q_t     reward,
    input  ql_pkg::q_row_t next_row,
    input  logic           terminal,
    output ql_pkg::q_t     q_new
);

    ql_pkg::q_t         row_max;
    logic signed [18:0] max_q;
    logic signed [18:0] discounted;
    logic signed [18:0] td_err;
    logic signed [18:0] sum;

    always_comb begin
        row_max = next_row[0];
        for (int i = 1; i < 4; i++) begin
            if (next_row[i] > row_max) begin
                row_max = next_row[i];
            end
        end
    end

    always_comb begin
        // no future value past a terminal cell
        if (terminal) begin
            max_q = '0;
        end else begin
            max_q = row_max;
        end
        discounted = max_q - (max_q >>> `QL_GAMMA_SHIFT);
        td_err     = reward + discounted - q_old;
        sum        = q_old + (td_err >>> `QL_ALPHA_SHIFT);

        // clamp back into 8.8
        if (sum > 19'sd32767) begin
            q_new = 16'sh7FFF;
        end else if (sum < -19'sd32768) begin
            q_new = 16'sh8000;
        end else begin
            q_new = sum[15:0];
        end
    end

endmodule

// ==== rtl/ql_agent.sv ====
`timescale 1ns/100ps

module ql_agent (
    input  logic            clk,
    input  logic            reset,
    input  logic            enb,
    input  logic [15:0]     epsilon,
    input  ql_pkg::action_t next_action,
    output ql_pkg::state_t  current_st,
    output ql_pkg::action_t action,
    output logic [8:0]      episode,
    output logic            step_done,
    output logic            fail,
    output logic            finish,
    output logic            done
);

    logic                sel_en;
    logic                move_en;
    logic                wr_en;
    logic                start_episode;
    ql_pkg::env_result_t env_res;
    ql_pkg::q_row_t      row_cur;
    ql_pkg::q_row_t      row_next;
    ql_pkg::q_t          q_new;

    control_unit u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .enb           (enb),
        .result        (env_res),
        .sel_en        (sel_en),
        .move_en       (move_en),
        .wr_en         (wr_en),
        .start_episode (start_episode),
        .step_done     (step_done),
        .fail          (fail),
        .finish        (finish),
        .episode       (episode),
        .done          (done)
    );

    grid_env u_env (
        .clk           (clk),
        .reset         (reset),
        .start_episode (start_episode),
        .move_en       (move_en),
        .action        (action),
        .current_st    (current_st),
        .result        (env_res)
    );

    // written entry belongs to the state the step left
    q_table u_table (
        .clk        (clk),
        .reset      (reset),
        .rd_state_a (current_st),
        .rd_row_a   (row_cur),
        .rd_state_b (env_res.next_state),
        .rd_row_b   (row_next),
        .wr_en      (wr_en),
        .wr_state   (current_st),
        .wr_action  (action),
        .wr_value   (q_new)
    );

    action_select u_select (
        .clk         (clk),
        .reset       (reset),
        .sel_en      (sel_en),
        .epsilon     (epsilon),
        .next_action (next_action),
        .q_row       (row_cur),
        .action      (action)
    );

    q_update u_update (
        .q_old    (row_cur[action]),
        .reward   (env_res.reward),
        .next_row (row_next),
        .terminal (env_res.hole | env_res.goal),
        .q_new    (q_new)
    );

endmodule

// ==== rtl/ql_cfg.svh ====
`ifndef QL_CFG_SVH
`define QL_CFG_SVH

// grid geometry, cell = row * N + col
`define QL_GRID_N 5
`define QL_STATES 25

`define QL_START 5'd0
`define QL_GOAL 5'd24

// holes at cells 5, 7, 13, 17 and 21
`define QL_HOLE_MASK 25'h02220A0

// rewards in 8.8 fixed point
`define QL_R_GOAL 16'sh0A00
`define QL_R_HOLE 16'shFC00
`define QL_R_STEP 16'sh0000

// alpha = 1/4, gamma = 7/8
`define QL_ALPHA_SHIFT 2
`define QL_GAMMA_SHIFT 3

`define QL_MAX_EPISODES 9'd10

`endif

// ==== rtl/ql_pkg.sv ====
package ql_pkg;

    // cell index, row * 5 + col
    typedef logic [4:0] state_t;

    // move direction
    typedef logic [1:0] action_t;

    localparam action_t ACT_UP    = 2'd0;
    localparam action_t ACT_DOWN  = 2'd1;
    localparam action_t ACT_LEFT  = 2'd2;
    localparam action_t ACT_RIGHT = 2'd3;

    // 8.8 fixed point
    typedef logic signed [15:0] q_t;

    // one value per action, indexed by action_t
    typedef q_t [3:0] q_row_t;

    // outcome of one move
    typedef struct packed {
        state_t next_state;
        q_t     reward;
        logic   hole;
        logic   goal;
    } env_result_t;

endpackage

// ==== testbench/ql_agent_assertions.sv ====
`timescale 1ns/100ps
`include "ql_cfg.svh"

module ql_agent_assertions (
    input  logic            clk,
    input  logic            reset,
    input  logic            sel_en,
    input  logic [15:0]     epsilon,
    input  ql_pkg::action_t next_action,
    input  ql_pkg::state_t  current_st,
    input  ql_pkg::action_t action,
    input  logic [8:0]      episode,
    input  logic            step_done,
    input  logic            fail,
    input  logic            finish,
    input  logic            done
);

    localparam logic [`QL_STATES-1:0] holes = `QL_HOLE_MASK;

    int             fail_count = 0;
    ql_pkg::state_t prev_st;
    ql_pkg::state_t target;
    ql_pkg::state_t expect_st;
    logic           target_hole;
    logic           target_goal;
    logic           end_step;

    // destination cell, walls hold the agent in place
    function automatic ql_pkg::state_t step_to(ql_pkg::state_t st, ql_pkg::action_t act);
        int r;
        int c;
        r = st / `QL_GRID_N;
        c = st % `QL_GRID_N;
        case (act)
            2'd0: r = (r > 0) ? r - 1 : r;
            2'd1: r = (r < `QL_GRID_N - 1) ? r + 1 : r;
            2'd2: c = (c > 0) ? c - 1 : c;
            default: c = (c < `QL_GRID_N - 1) ? c + 1 : c;
        endcase
        return ql_pkg::state_t'(r * `QL_GRID_N + c);
    endfunction

    // current_st one cycle back, the cell the step started from
    always_ff @(posedge clk) begin
        prev_st <= current_st;
    end

    assign target      = step_to(prev_st, action);
    assign target_hole = holes[target];
    assign target_goal = (target == `QL_GOAL);
    assign expect_st   = (target_hole || target_goal) ? `QL_START : target;
    assign end_step    = step_done && (fail || finish);

    a_reset: assert property (@(posedge clk)
        reset |=> (current_st == `QL_START) && (episode == 9'd0) && !step_done
                  && !fail && !finish && !done)
        else begin
            fail_count++;
            $error("outputs do not hold their reset values after reset");
        end

    // four cycles from SELECT, and nothing once done
    a_step_timing: assert property (@(posedge clk) disable iff (reset)
        step_done == ($past(sel_en, 4) && !done))
        else begin
            fail_count++;
            $error("FAIL step_done %h expected %h", $sampled(step_done),
                   $sampled($past(sel_en, 4) && !done));
        end

    a_move: assert property (@(posedge clk) disable iff (reset)
        step_done |-> current_st == expect_st)
        else begin
            fail_count++;
            $error("FAIL current_st %h expected %h", $sampled(current_st),
                   $sampled(expect_st));
        end

    a_flags: assert property (@(posedge clk) disable iff (reset)
        (fail == (step_done && target_hole)) && (finish == (step_done && target_goal)))
        else begin
            fail_count++;
            $error("FAIL fail/finish %h/%h expected %h/%h", $sampled(fail),
                   $sampled(finish), $sampled(step_done && target_hole),
                   $sampled(step_done && target_goal));
        end

    a_episode: assert property (@(posedge clk) disable iff (reset)
        episode == (end_step ? $past(episode) + 9'd1 : $past(episode)))
        else begin
            fail_count++;
            $error("FAIL episode %h previous %h", $sampled(episode),
                   $sampled($past(episode)));
        end

    a_done: assert property (@(posedge clk) disable iff (reset)
        done == ($past(episode) == `QL_MAX_EPISODES))
        else begin
            fail_count++;
            $error("FAIL done %h episode %h", $sampled(done), $sampled(episode));
        end

    a_explore: assert property (@(posedge clk) disable iff (reset)
        $past(sel_en) && ($past(epsilon) == 16'hFFFF) |-> action == $past(next_action))
        else begin
            fail_count++;
            $error("FAIL action %h expected %h", $sampled(action),
                   $sampled($past(next_action)));
        end

    // all-zero table, greedy pick is up
    a_greedy_act: assert property (@(posedge clk) disable iff (reset)
        $past(sel_en) && ($past(epsilon) == 16'h0000) && ($past(episode) == 9'd0)
        |-> action == ql_pkg::ACT_UP)
        else begin
            fail_count++;
            $error("FAIL action %h expected %h", $sampled(action), ql_pkg::ACT_UP);
        end

    a_greedy_stay: assert property (@(posedge clk) disable iff (reset)
        step_done && ($past(epsilon, 4) == 16'h0000) && ($past(episode) == 9'd0)
        |-> current_st == `QL_START)
        else begin
            fail_count++;
            $error("FAIL current_st %h expected %h", $sampled(current_st), `QL_START);
        end

endmodule

// ==== testbench/ql_agent_tb.sv ====
`timescale 1ns/100ps
`include "ql_cfg.svh"

module ql_agent_tb;

    localparam int clk_period    = 4;
    localparam int greedy_steps  = 20;
    localparam int route_steps   = 9;
    // loose bound on random steps up to the episode limit
    localparam int random_budget = `QL_MAX_EPISODES * 400;
    localparam int timeout_ns    =
        ((greedy_steps + route_steps + random_budget) * 4 + 200) * clk_period;

    logic            clk = 1'b0;
    logic            reset;
    logic            enb;
    logic [15:0]     epsilon;
    ql_pkg::action_t next_action;
    ql_pkg::state_t  current_st;
    ql_pkg::action_t action;
    logic [8:0]      episode;
    logic            step_done;
    logic            fail;
    logic            finish;
    logic            done;
    integer          seed = 9926;
    integer          rnd;

    // into the hole below start, then along the top row and down to the goal
    ql_pkg::action_t route [route_steps] = '{
        ql_pkg::ACT_DOWN,
        ql_pkg::ACT_RIGHT, ql_pkg::ACT_RIGHT, ql_pkg::ACT_RIGHT, ql_pkg::ACT_RIGHT,
        ql_pkg::ACT_DOWN, ql_pkg::ACT_DOWN, ql_pkg::ACT_DOWN, ql_pkg::ACT_DOWN
    };

    ql_agent dut (
        .clk         (clk),
        .reset       (reset),
        .enb         (enb),
        .epsilon     (epsilon),
        .next_action (next_action),
        .current_st  (current_st),
        .action      (action),
        .episode     (episode),
        .step_done   (step_done),
        .fail        (fail),
        .finish      (finish),
        .done        (done)
    );

    bind ql_agent ql_agent_assertions u_checks (
        .clk         (clk),
        .reset       (reset),
        .sel_en      (sel_en),
        .epsilon     (epsilon),
        .next_action (next_action),
        .current_st  (current_st),
        .action      (action),
        .episode     (episode),
        .step_done   (step_done),
        .fail        (fail),
        .finish      (finish),
        .done        (done)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    // return in the cycle of the next step_done, or once done is up
    task automatic next_step();
        do begin
            @(posedge clk);
            #1;
        end while (!step_done && !done);
    endtask

    initial begin
        #(timeout_ns);
        abort_run("timeout, the agent did not reach the episode limit in time");
    end

    initial begin
        wait (dut.u_checks.fail_count != 0);
        abort_run("an assertion on the agent outputs failed");
    end

    initial begin
        reset       = 1'b1;
        enb         = 1'b0;
        epsilon     = 16'h0000;
        next_action = ql_pkg::ACT_UP;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        enb = 1'b1;

        // greedy steps on the fresh table
        repeat (greedy_steps) next_step();

        epsilon = 16'hFFFF;
        for (int i = 0; i < route_steps; i++) begin
            next_action = route[i];
            next_step();
        end

        // short stop through IDLE
        enb = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        enb = 1'b1;

        while (!done) begin
            rnd         = $random(seed);
            next_action = ql_pkg::action_t'(rnd[1:0]);
            next_step();
        end

        // no further steps may appear
        repeat (10) @(posedge clk);
        if (dut.u_checks.fail_count != 0) begin
            abort_run("assertion failures were counted during the run");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/ql_pkg.sv
rtl/grid_env.sv
rtl/q_table.sv
rtl/action_select.sv
rtl/q_update.sv
rtl/control_unit.sv
rtl/ql_agent.sv
testbench/ql_agent_assertions.sv
testbench/ql_agent_tb.sv
